// File: fetch_front.f
+incdir+.
source/fetch_pkg.sv
source/pc_gen.sv
source/addr_trans.sv
source/inst_rom.sv
source/excp_csr.sv
source/fetch_front.sv
tb/tb_fetch_front.sv

// File: tb/tb_fetch_front.sv
`default_nettype none

`include "fetch_front_settings.svh"

module tb_fetch_front;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 5;
  localparam int ROM_WORDS = 1 << `FETCH_ROM_AW;
  localparam int SEQ_PKTS = 32;
  localparam int BP_PKTS = 48;
  localparam int BP_LIMIT = 400;
  // per-wait bound in cycles
  localparam int WAIT_LIMIT = 64;
  // waits over all directed tests
  localparam int WAIT_CALLS = 15;
  // pulses, csr write and reset checks
  localparam int FIXED_CYCLES = 40;
  localparam int MARGIN_CYCLES = 200;
  localparam int RUN_CYCLES = 2 * RST_CYCLES + ROM_WORDS + BP_LIMIT
                              + WAIT_CALLS * WAIT_LIMIT + FIXED_CYCLES;
  localparam int WATCHDOG_NS = (RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic                  clk;
  logic                  rst_n;
  fetch_pkg::redirect_t  branch;
  logic                  ertn;
  fetch_pkg::csr_wr_t    csr_wr;
  fetch_pkg::imem_wr_t   imem_wr;
  logic                  id_ready;
  fetch_pkg::fetch_pkt_t fetch_out;
  logic                  excp_taken;
  logic [31:0]           era;

  // rom image and reference model state
  logic [31:0] rom_copy [ROM_WORDS];
  logic [31:0] exp_pc;
  logic [31:0] model_eentry;
  logic [31:0] model_era;
  logic [31:0] last_pc;
  logic [31:0] prev_pc;
  logic        prev_stall;
  logic        checking;
  logic [31:0] lfsr_state;
  int          consumed_cnt;
  int          excp_cnt;
  int          err_cnt;

  fetch_front u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .branch     (branch),
    .ertn       (ertn),
    .csr_wr     (csr_wr),
    .imem_wr    (imem_wr),
    .id_ready   (id_ready),
    .fetch_out  (fetch_out),
    .excp_taken (excp_taken),
    .era        (era)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_error(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_bit()};
    end
    return val;
  endfunction

  // segment miss or not word aligned
  function automatic logic addr_fault(input logic [31:0] va);
    return (va[31:28] != `FETCH_WIN_SEG) || (va[1:0] != 2'b00);
  endfunction

  // word index of the translated address
  function automatic logic [`FETCH_ROM_AW-1:0] rom_index(input logic [31:0] va);
    logic [31:0] pa;
    pa = {4'h0, va[27:0]};
    return pa[`FETCH_ROM_AW+1:2];
  endfunction

  // reference model, sampled mid-cycle
  // a packet taken on a redirect cycle still counts as consumed
  always @(negedge clk) begin
    if (checking && rst_n) begin
      if (prev_stall) begin
        assert (fetch_out.valid)
          else report_error($sformatf("ERROR: fetch_out.valid under stall got %h expected %h",
                                      fetch_out.valid, 1'b1));
        assert (fetch_out.pc == prev_pc)
          else report_error($sformatf("ERROR: fetch_out.pc under stall got %h expected %h",
                                      fetch_out.pc, prev_pc));
      end
      prev_stall = fetch_out.valid && !id_ready && !branch.valid && !ertn && !excp_taken;
      prev_pc    = fetch_out.pc;
      if (fetch_out.valid && id_ready) begin
        assert (!addr_fault(exp_pc))
          else report_error($sformatf("packet consumed while a fault at %h was due", exp_pc));
        assert (fetch_out.pc == exp_pc)
          else report_error($sformatf("ERROR: fetch_out.pc got %h expected %h",
                                      fetch_out.pc, exp_pc));
        assert (fetch_out.adef == 1'b0)
          else report_error($sformatf("ERROR: fetch_out.adef got %h expected %h",
                                      fetch_out.adef, 1'b0));
        assert (fetch_out.inst == rom_copy[rom_index(exp_pc)])
          else report_error($sformatf("ERROR: fetch_out.inst got %h expected %h",
                                      fetch_out.inst, rom_copy[rom_index(exp_pc)]));
        last_pc = fetch_out.pc;
        exp_pc  = exp_pc + 32'd4;
        consumed_cnt++;
      end
      // exception beats return, return beats branch
      if (excp_taken) begin
        assert (addr_fault(exp_pc))
          else report_error($sformatf("exception raised on the good address %h", exp_pc));
        assert (fetch_out.pc == exp_pc)
          else report_error($sformatf("ERROR: fetch_out.pc at exception got %h expected %h",
                                      fetch_out.pc, exp_pc));
        assert (fetch_out.adef == 1'b1)
          else report_error($sformatf("ERROR: fetch_out.adef at exception got %h expected %h",
                                      fetch_out.adef, 1'b1));
        assert (!fetch_out.valid)
          else report_error($sformatf("ERROR: fetch_out.valid at exception got %h expected %h",
                                      fetch_out.valid, 1'b0));
        model_era = exp_pc;
        exp_pc    = model_eentry;
        excp_cnt++;
      end else if (ertn) begin
        exp_pc = model_era;
      end else if (branch.valid) begin
        exp_pc = branch.target;
      end
      // new entry only counts from the next edge on
      if (csr_wr.we) begin
        model_eentry = csr_wr.data;
      end
    end
  end

  task automatic apply_reset();
    rst_n <= 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    exp_pc       = `FETCH_RESET_PC;
    model_eentry = `FETCH_EENTRY_RESET;
    model_era    = 32'h0;
    prev_stall   = 1'b0;
    rst_n <= 1'b1;
    checking = 1'b1;
    @(negedge clk);
    assert (!fetch_out.valid)
      else report_error($sformatf("ERROR: fetch_out.valid after reset got %h expected %h",
                                  fetch_out.valid, 1'b0));
    assert (!excp_taken)
      else report_error($sformatf("ERROR: excp_taken after reset got %h expected %h",
                                  excp_taken, 1'b0));
  endtask

  // load every rom word, fetch runs unchecked meanwhile
  task automatic fill_rom();
    logic [31:0] word;
    checking = 1'b0;
    @(posedge clk);
    id_ready <= 1'b1;
    for (int i = 0; i < ROM_WORDS; i++) begin
      @(posedge clk);
      word        = rand_bits(32);
      rom_copy[i] = word;
      imem_wr <= '{we: 1'b1, addr: i[`FETCH_ROM_AW-1:0], data: word};
    end
    @(posedge clk);
    imem_wr <= '0;
    id_ready <= 1'b0;
  endtask

  task automatic wait_packets(input int n);
    int target;
    int cycles;
    target = consumed_cnt + n;
    cycles = 0;
    while (consumed_cnt < target && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    assert (consumed_cnt >= target)
      else report_error($sformatf("timed out waiting for %0d packets", n));
  endtask

  task automatic wait_exception();
    int target;
    int cycles;
    target = excp_cnt + 1;
    cycles = 0;
    while (excp_cnt < target && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    assert (excp_cnt >= target)
      else report_error("timed out waiting for an exception");
  endtask

  task automatic drive_branch(input logic [31:0] target);
    @(posedge clk);
    branch <= '{valid: 1'b1, target: target};
    @(posedge clk);
    branch <= '0;
  endtask

  task automatic write_eentry(input logic [31:0] val);
    @(posedge clk);
    csr_wr <= '{we: 1'b1, data: val};
    @(posedge clk);
    csr_wr <= '0;
  endtask

  task automatic pulse_ertn();
    @(posedge clk);
    ertn <= 1'b1;
    @(posedge clk);
    ertn <= 1'b0;
  endtask

  // era settles at the edge after the exception cycle
  task automatic check_era(input logic [31:0] expected);
    @(negedge clk);
    assert (era == expected)
      else report_error($sformatf("ERROR: era got %h expected %h", era, expected));
  endtask

  task automatic sequential_fetch();
    int excp_start;
    excp_start = excp_cnt;
    @(posedge clk);
    id_ready <= 1'b1;
    wait_packets(SEQ_PKTS);
    assert (last_pc == `FETCH_RESET_PC + 32'd4 * (SEQ_PKTS - 1))
      else report_error($sformatf("ERROR: fetch_out.pc got %h expected %h", last_pc,
                                  `FETCH_RESET_PC + 32'd4 * (SEQ_PKTS - 1)));
    assert (excp_cnt == excp_start)
      else report_error("exception raised during sequential fetch");
  endtask

  // random decode stalls, order checked by the model
  task automatic backpressure_fetch();
    int start;
    int cycles;
    start  = consumed_cnt;
    cycles = 0;
    while (consumed_cnt < start + BP_PKTS && cycles < BP_LIMIT) begin
      @(posedge clk);
      id_ready <= lfsr_bit();
      cycles++;
    end
    assert (consumed_cnt >= start + BP_PKTS)
      else report_error("too few packets consumed under back-pressure");
    @(posedge clk);
    id_ready <= 1'b1;
  endtask

  task automatic branch_redirect();
    logic [31:0] target;
    target = `FETCH_RESET_PC + 32'h0000_0800 + (rand_bits(8) << 2);
    wait_packets(4);
    drive_branch(target);
    wait_packets(1);
    assert (last_pc == target)
      else report_error($sformatf("ERROR: fetch_out.pc after branch got %h expected %h",
                                  last_pc, target));
    wait_packets(8);
  endtask

  task automatic fault_redirect();
    logic [31:0] bad;
    logic [31:0] entry;
    // misaligned target, default entry
    bad = `FETCH_RESET_PC + 32'h0000_0202;
    drive_branch(bad);
    wait_exception();
    check_era(bad);
    wait_packets(1);
    assert (last_pc == `FETCH_EENTRY_RESET)
      else report_error($sformatf("ERROR: fetch_out.pc after fault got %h expected %h",
                                  last_pc, `FETCH_EENTRY_RESET));
    wait_packets(3);
    // outside the window, software entry
    entry = `FETCH_RESET_PC + 32'h0000_0400;
    write_eentry(entry);
    bad = {`FETCH_WIN_SEG + 4'h1, 28'h0} | (rand_bits(26) << 2);
    drive_branch(bad);
    wait_exception();
    check_era(bad);
    wait_packets(1);
    assert (last_pc == entry)
      else report_error($sformatf("ERROR: fetch_out.pc after fault got %h expected %h",
                                  last_pc, entry));
    wait_packets(3);
  endtask

  // era points at the bad address, so the return faults again
  task automatic return_redirect();
    logic [31:0] bad;
    bad = `FETCH_RESET_PC + 32'h0000_0301;
    drive_branch(bad);
    wait_exception();
    check_era(bad);
    wait_packets(4);
    pulse_ertn();
    wait_exception();
    check_era(bad);
    wait_packets(1);
    assert (last_pc == model_eentry)
      else report_error($sformatf("ERROR: fetch_out.pc after return got %h expected %h",
                                  last_pc, model_eentry));
    wait_packets(3);
  endtask

  initial begin
    #(WATCHDOG_NS);
    report_error($sformatf("watchdog expired after %0d ns, the run did not finish",
                           WATCHDOG_NS));
  end

  initial begin
    rst_n        = 1'b0;
    branch       = '0;
    ertn         = 1'b0;
    csr_wr       = '0;
    imem_wr      = '0;
    id_ready     = 1'b0;
    checking     = 1'b0;
    prev_stall   = 1'b0;
    consumed_cnt = 0;
    excp_cnt     = 0;
    err_cnt      = 0;
    lfsr_state   = 32'd84716;
    apply_reset();
    fill_rom();
    // clean start from the reset vector with the rom loaded
    apply_reset();
    sequential_fetch();
    backpressure_fetch();
    branch_redirect();
    fault_redirect();
    return_redirect();
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/fetch_front.sv
`default_nettype none

`include "fetch_front_settings.svh"

module fetch_front (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fetch_pkg::redirect_t  branch,
  input  logic                  ertn,
  input  fetch_pkg::csr_wr_t    csr_wr,
  input  fetch_pkg::imem_wr_t   imem_wr,
  input  logic                  id_ready,
  output fetch_pkg::fetch_pkt_t fetch_out,
  output logic                  excp_taken,
  output logic [31:0]           era
);

  fetch_pkg::fetch_req_t    req;
  fetch_pkg::fetch_pkt_t    pkt;
  logic                     trans_ready;
  logic                     kill;
  logic                     excp_flush;
  logic                     ertn_flush;
  logic [31:0]              eentry;
  logic                     rom_rd_en;
  logic [`FETCH_ROM_AW-1:0] rom_rd_addr;
  logic [31:0]              rom_rd_data;

  // every redirect empties the translation stage
  assign kill = excp_flush | ertn_flush | branch.valid;

  // pc register and redirect select
  pc_gen u_pc_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .excp_flush  (excp_flush),
    .ertn_flush  (ertn_flush),
    .eentry      (eentry),
    .era         (era),
    .branch      (branch),
    .trans_ready (trans_ready),
    .req         (req)
  );

  // window check and fetch register
  addr_trans u_addr_trans (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .trans_ready (trans_ready),
    .kill        (kill),
    .id_ready    (id_ready),
    .rom_rd_en   (rom_rd_en),
    .rom_rd_addr (rom_rd_addr),
    .rom_rd_data (rom_rd_data),
    .pkt         (pkt)
  );

  inst_rom u_inst_rom (
    .clk     (clk),
    .wr      (imem_wr),
    .rd_en   (rom_rd_en),
    .rd_addr (rom_rd_addr),
    .rd_data (rom_rd_data)
  );

  // entry and return registers, flush generation
  excp_csr u_excp_csr (
    .clk        (clk),
    .rst_n      (rst_n),
    .pkt        (pkt),
    .ertn       (ertn),
    .csr_wr     (csr_wr),
    .excp_flush (excp_flush),
    .ertn_flush (ertn_flush),
    .eentry     (eentry),
    .era        (era)
  );

  // decode never sees a faulting entry as valid
  assign fetch_out = '{valid: pkt.valid & ~pkt.adef, pc: pkt.pc, inst: pkt.inst, adef: pkt.adef};

  assign excp_taken = excp_flush;

endmodule

`default_nettype wire

// File: source/excp_csr.sv
`default_nettype none

`include "fetch_front_settings.svh"

module excp_csr (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fetch_pkg::fetch_pkt_t pkt,
  input  logic                  ertn,
  input  fetch_pkg::csr_wr_t    csr_wr,
  output logic                  excp_flush,
  output logic                  ertn_flush,
  output logic [31:0]           eentry,
  output logic [31:0]           era
);

  logic [31:0] eentry_q;
  logic [31:0] era_q;

  // fault raised while the bad entry sits in the stage
  // the stage clears at the next edge, so this is a single-cycle pulse
  assign excp_flush = pkt.valid & pkt.adef;

  // return suppressed under a same-cycle exception
  assign ertn_flush = ertn & ~excp_flush;

  // exception entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      eentry_q <= `FETCH_EENTRY_RESET;
    end else if (csr_wr.we) begin
      eentry_q <= csr_wr.data;
    end
  end

  // return address
  // captures the faulting pc
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      era_q <= 32'h0;
    end else if (excp_flush) begin
      era_q <= pkt.pc;
    end
  end

  assign eentry = eentry_q;
  assign era    = era_q;

  // translation drops the faulting entry at the flush edge
  property p_excp_pulse;
    @(posedge clk) disable iff (!rst_n)
      excp_flush |=> !excp_flush;
  endproperty
  a_excp_pulse: assert property (p_excp_pulse)
    else $error("excp_csr: exception flush held past one cycle, pc %h", pkt.pc);

endmodule

`default_nettype wire

// File: source/inst_rom.sv
`default_nettype none

`include "fetch_front_settings.svh"

module inst_rom (
  input  logic                     clk,
  input  fetch_pkg::imem_wr_t      wr,
  input  logic                     rd_en,
  input  logic [`FETCH_ROM_AW-1:0] rd_addr,
  output logic [31:0]              rd_data
);

  localparam int unsigned DEPTH = 1 << `FETCH_ROM_AW;

  // word array
  logic [31:0] mem [DEPTH];

  // load port
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // registered read
  // output held while the fetch stalls
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: source/addr_trans.sv
`default_nettype none

`include "fetch_front_settings.svh"

module addr_trans (
  input  logic                     clk,
  input  logic                     rst_n,
  input  fetch_pkg::fetch_req_t    req,
  output logic                     trans_ready,
  input  logic                     kill,
  input  logic                     id_ready,
  output logic                     rom_rd_en,
  output logic [`FETCH_ROM_AW-1:0] rom_rd_addr,
  input  logic [31:0]              rom_rd_data,
  output fetch_pkg::fetch_pkt_t    pkt
);

  logic [31:0] paddr;
  logic        seg_hit;
  logic        misalign;
  logic        adef;
  logic        fire;
  logic        leave;
  logic        ent_valid;
  logic [31:0] ent_pc;
  logic        ent_adef;

  // window check on the top nibble
  assign seg_hit  = (req.pc[31:28] == `FETCH_WIN_SEG);
  // word fetch only
  assign misalign = (req.pc[1:0] != 2'b00);
  assign adef     = ~seg_hit | misalign;

  // direct map, segment bits dropped
  assign paddr = {4'h0, req.pc[27:0]};

  // entry consumed by decode
  // faulting entries are never shown, they wait for the exception flush
  assign leave = ent_valid & ~ent_adef & id_ready;

  // room when empty or draining this cycle
  assign trans_ready = ~ent_valid | leave;
  assign fire        = req.valid & trans_ready;

  // rom read in step with the fire
  assign rom_rd_en   = fire;
  assign rom_rd_addr = paddr[`FETCH_ROM_AW+1:2];

  // entry valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ent_valid <= 1'b0;
    end else if (kill) begin
      // redirect wins over a same-cycle fire
      ent_valid <= 1'b0;
    end else if (fire) begin
      ent_valid <= 1'b1;
    end else if (leave) begin
      ent_valid <= 1'b0;
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (fire) begin
      ent_pc   <= req.pc;
      ent_adef <= adef;
    end
  end

  // instruction comes straight off the rom register
  assign pkt = '{valid: ent_valid, pc: ent_pc, inst: rom_rd_data, adef: ent_adef};

  // a stalled entry keeps the pc generator on the next address
  property p_entry_hold;
    @(posedge clk) disable iff (!rst_n)
      (ent_valid && !leave && !kill) |=> $stable(req.pc);
  endproperty
  a_entry_hold: assert property (p_entry_hold)
    else $error("addr_trans: request pc moved under a stall, pc %h", req.pc);

endmodule

`default_nettype wire

// File: source/pc_gen.sv
`default_nettype none

`include "fetch_front_settings.svh"

module pc_gen (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  excp_flush,
  input  logic                  ertn_flush,
  input  logic [31:0]           eentry,
  input  logic [31:0]           era,
  input  fetch_pkg::redirect_t  branch,
  input  logic                  trans_ready,
  output fetch_pkg::fetch_req_t req
);

  logic [31:0] pc;
  logic        pc_valid;
  logic        fire;

  // handshake with translation
  assign fire = pc_valid & trans_ready;

  // next pc selection
  // exception beats return, return beats branch
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `FETCH_RESET_PC;
    end else if (excp_flush) begin
      pc <= eentry;
    end else if (ertn_flush) begin
      pc <= era;
    end else if (branch.valid) begin
      pc <= branch.target;
    end else if (fire) begin
      // sequential step, only once the address was taken
      pc <= pc + 32'd4;
    end
  end

  // request valid
  // low in reset, up on the first cycle after
  // a redirect finds it already up, it stays up while fetching
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_valid <= 1'b0;
    end else begin
      pc_valid <= 1'b1;
    end
  end

  assign req = '{pc: pc, valid: pc_valid};

  // request must be known once out of reset
  property p_req_valid_known;
    @(posedge clk) disable iff (!rst_n)
      !$isunknown(req);
  endproperty
  a_req_valid_known: assert property (p_req_valid_known)
    else $error("pc_gen: req unknown after reset, pc %h valid %b", req.pc, req.valid);

endmodule

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

`include "fetch_front_settings.svh"

package fetch_pkg;

  // redirect request from a branch
  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  // pc generator to translation
  typedef struct packed {
    logic [31:0] pc;
    logic        valid;
  } fetch_req_t;

  // registered fetch entry toward decode
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] inst;
    // address fault, segment miss or misaligned
    logic        adef;
  } fetch_pkt_t;

  // exception entry write
  typedef struct packed {
    logic        we;
    logic [31:0] data;
  } csr_wr_t;

  // instruction memory load port
  typedef struct packed {
    logic                     we;
    logic [`FETCH_ROM_AW-1:0] addr;
    logic [31:0]              data;
  } imem_wr_t;

endpackage

`default_nettype wire

// File: fetch_front_settings.svh
`ifndef FETCH_FRONT_SETTINGS_SVH
`define FETCH_FRONT_SETTINGS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 32'h1C00_0000

// exception entry until software writes its own
`define FETCH_EENTRY_RESET 32'h1C00_0100

// top nibble of the virtual address accepted by the direct-mapped window
`define FETCH_WIN_SEG 4'h1

// instruction memory word address width
`define FETCH_ROM_AW 10

`endif
